// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] xlen_t;
    typedef logic [15:0] ghist_t;
    typedef logic [7:0]  btb_idx_t;
    typedef logic [13:0] btb_tag_t;
    typedef logic [8:0]  pht_idx_t;
    typedef logic [1:0]  ctr_t;
    typedef logic [5:0]  ras_ptr_t;

    // table sizes
    localparam int RAS_DEPTH   = 32;
    localparam int BTB_ENTRIES = 256;
    localparam int PHT_ENTRIES = 512;

    // weakly not-taken
    localparam ctr_t CTR_INIT = 2'd1;

    // rv32 opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [4:0] REG_RA = 5'd1;

    localparam xlen_t INST_STEP = 32'd4;

    // jal also counts as a call
    typedef enum logic [2:0] {
        BR_NONE,
        BR_BRANCH,
        BR_JAL,
        BR_JALR,
        BR_CALL_JALR,
        BR_RET
    } br_kind_t;

    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } if_req_t;

    // pdt_true set when the earlier prediction was right
    typedef struct packed {
        logic   valid;
        logic   taken;
        logic   pdt_true;
        xlen_t  pc;
        ghist_t history;
        xlen_t  target;
        xlen_t  inst;
    } ex_res_t;

    typedef struct packed {
        logic  is_branch;
        logic  taken;
        xlen_t target;
    } pred_t;

endpackage

// ==== rtl/bpu_ctrl.sv ====
`timescale 1ns/10ps

module bpu_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  bpu_pkg::if_req_t  if_i,
    input  bpu_pkg::ex_res_t  ex_i,
    input  logic              if_stall_i,
    input  logic              flush_i,
    input  logic              btb_hit_i,
    input  bpu_pkg::xlen_t    btb_target_i,
    input  bpu_pkg::ctr_t     pht_ctr_i,
    input  bpu_pkg::xlen_t    ras_top_i,
    input  logic              ras_empty_i,
    output bpu_pkg::btb_idx_t btb_rd_idx_o,
    output bpu_pkg::btb_tag_t btb_rd_tag_o,
    output logic              btb_wr_o,
    output bpu_pkg::btb_idx_t btb_wr_idx_o,
    output bpu_pkg::btb_tag_t btb_wr_tag_o,
    output bpu_pkg::xlen_t    btb_wr_target_o,
    output bpu_pkg::pht_idx_t pht_rd_idx_o,
    output logic              pht_upd_o,
    output bpu_pkg::pht_idx_t pht_upd_idx_o,
    output logic              pht_upd_taken_o,
    output logic              ras_push_o,
    output bpu_pkg::xlen_t    ras_push_data_o,
    output logic              ras_pop_o,
    output bpu_pkg::pred_t    pred_o,
    output bpu_pkg::ghist_t   history_o
);
    import bpu_pkg::*;

    // ret is jalr x0, 0(ra); a jalr writing a register is a call
    function automatic br_kind_t classify(xlen_t inst);
        br_kind_t kind;
        kind = BR_NONE;
        case (inst[6:0])
            OPC_BRANCH: kind = BR_BRANCH;
            OPC_JAL:    kind = BR_JAL;
            OPC_JALR: begin
                if (inst[11:7] == '0 && inst[19:15] == REG_RA)
                    kind = BR_RET;
                else if (inst[11:7] != '0)
                    kind = BR_CALL_JALR;
                else
                    kind = BR_JALR;
            end
            default:    kind = BR_NONE;
        endcase
        return kind;
    endfunction

    br_kind_t if_kind;
    br_kind_t ex_kind;
    xlen_t    br_off;
    xlen_t    jal_off;
    xlen_t    pc_next;
    logic     accept;
    ghist_t   ghist;

    assign if_kind = classify(if_i.inst);
    assign ex_kind = classify(ex_i.inst);

    // b-type and j-type immediates
    assign br_off  = {{20{if_i.inst[31]}}, if_i.inst[7], if_i.inst[30:25],
                      if_i.inst[11:8], 1'b0};
    assign jal_off = {{12{if_i.inst[31]}}, if_i.inst[19:12], if_i.inst[20],
                      if_i.inst[30:21], 1'b0};
    assign pc_next = if_i.pc + INST_STEP;

    assign btb_rd_idx_o = if_i.pc[9:2];
    assign btb_rd_tag_o = if_i.pc[31:18];
    assign pht_rd_idx_o = if_i.pc[9:1];

    always_comb begin
        pred_o.is_branch = 1'b0;
        pred_o.taken     = 1'b0;
        pred_o.target    = pc_next;
        if (!flush_i && !if_stall_i && if_kind != BR_NONE) begin
            pred_o.is_branch = 1'b1;
            case (if_kind)
                BR_RET: begin
                    if (!ras_empty_i) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = ras_top_i;
                    end else if (btb_hit_i) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = btb_target_i;
                    end
                end
                BR_JALR, BR_CALL_JALR: begin
                    if (btb_hit_i) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = btb_target_i;
                    end
                end
                BR_JAL: begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = if_i.pc + jal_off;
                end
                default: begin
                    // conditional branch, counter msb gives direction
                    if (pht_ctr_i[1]) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = btb_hit_i ? btb_target_i : if_i.pc + br_off;
                    end
                end
            endcase
        end
    end

    assign accept = ex_i.valid && !flush_i && !if_stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (flush_i) begin
            ghist <= ex_i.history;
        end else if (accept) begin
            ghist <= {ghist[$bits(ghist_t)-2:0], ex_i.taken};
        end
    end

    assign history_o = ghist;

    // table updates from the resolved result
    assign btb_wr_o        = accept && ex_i.taken && ex_kind != BR_NONE;
    assign btb_wr_idx_o    = ex_i.pc[9:2];
    assign btb_wr_tag_o    = ex_i.pc[31:18];
    assign btb_wr_target_o = ex_i.target;

    assign pht_upd_o       = accept && ex_kind == BR_BRANCH && !ex_i.pdt_true;
    assign pht_upd_idx_o   = ex_i.pc[9:1];
    assign pht_upd_taken_o = ex_i.taken;

    assign ras_push_o      = accept && (ex_kind == BR_JAL || ex_kind == BR_CALL_JALR);
    assign ras_push_data_o = ex_i.pc + INST_STEP;
    assign ras_pop_o       = accept && ex_kind == BR_RET;

endmodule

// ==== btb/bpu_btb.sv ====
`timescale 1ns/10ps

module bpu_btb (
    input  logic              clk,
    input  logic              rst,
    input  bpu_pkg::btb_idx_t rd_idx_i,
    input  bpu_pkg::btb_tag_t rd_tag_i,
    output logic              hit_o,
    output bpu_pkg::xlen_t    target_o,
    input  logic              wr_i,
    input  bpu_pkg::btb_idx_t wr_idx_i,
    input  bpu_pkg::btb_tag_t wr_tag_i,
    input  bpu_pkg::xlen_t    wr_target_i
);
    import bpu_pkg::*;

    logic [BTB_ENTRIES-1:0] valid;
    btb_tag_t               tag_mem [BTB_ENTRIES];
    xlen_t                  tgt_mem [BTB_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_i) begin
            valid[wr_idx_i] <= 1'b1;
        end
    end

    // tag and target arrays
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_mem[wr_idx_i] <= wr_tag_i;
            tgt_mem[wr_idx_i] <= wr_target_i;
        end
    end

    // async read for same-cycle prediction
    assign hit_o    = valid[rd_idx_i] && (tag_mem[rd_idx_i] == rd_tag_i);
    assign target_o = tgt_mem[rd_idx_i];

endmodule

// ==== pht/bpu_pht.sv ====
`timescale 1ns/10ps

module bpu_pht (
    input  logic              clk,
    input  logic              rst,
    input  bpu_pkg::pht_idx_t rd_idx_i,
    output bpu_pkg::ctr_t     ctr_o,
    input  logic              upd_i,
    input  bpu_pkg::pht_idx_t upd_idx_i,
    input  logic              upd_taken_i
);
    import bpu_pkg::*;

    ctr_t tbl [PHT_ENTRIES];
    ctr_t cur;
    ctr_t nxt;

    assign cur = tbl[upd_idx_i];

    // saturating step toward the outcome
    always_comb begin
        nxt = cur;
        if (upd_taken_i && cur != 2'd3)
            nxt = cur + 2'd1;
        else if (!upd_taken_i && cur != 2'd0)
            nxt = cur - 2'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                tbl[i] <= CTR_INIT;
            end
        end else if (upd_i) begin
            tbl[upd_idx_i] <= nxt;
        end
    end

    assign ctr_o = tbl[rd_idx_i];

endmodule

// ==== ras/bpu_ras.sv ====
`timescale 1ns/10ps

module bpu_ras (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::xlen_t push_data_i,
    input  logic           pop_i,
    output bpu_pkg::xlen_t top_o,
    output logic           empty_o
);
    import bpu_pkg::*;

    xlen_t    stack [RAS_DEPTH];
    ras_ptr_t ptr;
    ras_ptr_t top_idx;
    logic     full;

    // ptr counts entries, top sits one below
    assign top_idx = ptr - 6'd1;
    assign full    = (ptr == ras_ptr_t'(RAS_DEPTH));
    assign empty_o = (ptr == '0);
    assign top_o   = stack[top_idx[$clog2(RAS_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (push_i) begin
            // overflow wraps to the bottom entry
            ptr <= full ? 6'd1 : ptr + 6'd1;
        end else if (pop_i && !empty_o) begin
            ptr <= ptr - 6'd1;
        end
    end

    // a full stack has ptr 32, whose low bits select entry 0
    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[ptr[$clog2(RAS_DEPTH)-1:0]] <= push_data_i;
        end
    end

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/10ps

module bpu_top (
    input  logic             clk,
    input  logic             rst,
    input  bpu_pkg::if_req_t if_i,
    input  bpu_pkg::ex_res_t ex_i,
    input  logic             if_stall_i,
    input  logic             flush_i,
    output bpu_pkg::pred_t   pred_o,
    output bpu_pkg::ghist_t  history_o
);
    import bpu_pkg::*;

    btb_idx_t btb_rd_idx;
    btb_tag_t btb_rd_tag;
    logic     btb_hit;
    xlen_t    btb_target;
    logic     btb_wr;
    btb_idx_t btb_wr_idx;
    btb_tag_t btb_wr_tag;
    xlen_t    btb_wr_target;

    pht_idx_t pht_rd_idx;
    ctr_t     pht_ctr;
    logic     pht_upd;
    pht_idx_t pht_upd_idx;
    logic     pht_upd_taken;

    logic     ras_push;
    xlen_t    ras_push_data;
    logic     ras_pop;
    xlen_t    ras_top;
    logic     ras_empty;

    bpu_ctrl u_bpu_ctrl (
        .clk             (clk),
        .rst             (rst),
        .if_i            (if_i),
        .ex_i            (ex_i),
        .if_stall_i      (if_stall_i),
        .flush_i         (flush_i),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .pht_ctr_i       (pht_ctr),
        .ras_top_i       (ras_top),
        .ras_empty_i     (ras_empty),
        .btb_rd_idx_o    (btb_rd_idx),
        .btb_rd_tag_o    (btb_rd_tag),
        .btb_wr_o        (btb_wr),
        .btb_wr_idx_o    (btb_wr_idx),
        .btb_wr_tag_o    (btb_wr_tag),
        .btb_wr_target_o (btb_wr_target),
        .pht_rd_idx_o    (pht_rd_idx),
        .pht_upd_o       (pht_upd),
        .pht_upd_idx_o   (pht_upd_idx),
        .pht_upd_taken_o (pht_upd_taken),
        .ras_push_o      (ras_push),
        .ras_push_data_o (ras_push_data),
        .ras_pop_o       (ras_pop),
        .pred_o          (pred_o),
        .history_o       (history_o)
    );

    bpu_btb u_bpu_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_i    (btb_rd_idx),
        .rd_tag_i    (btb_rd_tag),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_i        (btb_wr),
        .wr_idx_i    (btb_wr_idx),
        .wr_tag_i    (btb_wr_tag),
        .wr_target_i (btb_wr_target)
    );

    bpu_pht u_bpu_pht (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_i    (pht_rd_idx),
        .ctr_o       (pht_ctr),
        .upd_i       (pht_upd),
        .upd_idx_i   (pht_upd_idx),
        .upd_taken_i (pht_upd_taken)
    );

    bpu_ras u_bpu_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_data_i (ras_push_data),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

endmodule

// ==== bench/bpu_assert.sv ====
`timescale 1ns/10ps

module bpu_assert (
    input logic           clk,
    input logic           rst,
    input logic           flush_i,
    input bpu_pkg::pred_t pred_i,
    input logic           ras_push_i,
    input logic           ras_pop_i
);

    // no control transfer predicted while flushing
    flush_no_branch: assert property (@(posedge clk) disable iff (rst)
        flush_i |-> !pred_i.is_branch)
        else $error("branch predicted during flush");

    taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        pred_i.taken |-> pred_i.is_branch)
        else $error("taken prediction without is_branch");

    // one ex result cannot be both call and return
    push_pop_excl: assert property (@(posedge clk) disable iff (rst)
        !(ras_push_i && ras_pop_i))
        else $error("ras push and pop in the same cycle");

endmodule

bind bpu_ctrl bpu_assert u_bpu_assert (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .pred_i     (pred_o),
    .ras_push_i (ras_push_o),
    .ras_pop_i  (ras_pop_o)
);

// ==== bench/tb_bpu.sv ====
`timescale 1ns/10ps

module tb_bpu;
    import bpu_pkg::*;

    // each test runs for a few dozen cycles, so this leaves a wide margin
    localparam int    WATCHDOG_CYCLES = 2000;
    localparam xlen_t NOP             = 32'h0000_0013;

    logic    clk;
    logic    rst;
    if_req_t if_q;
    ex_res_t ex_q;
    logic    stall_q;
    logic    flush_q;
    pred_t   pred;
    ghist_t  hist;
    ghist_t  exp_hist;

    bpu_top u_bpu_top (
        .clk        (clk),
        .rst        (rst),
        .if_i       (if_q),
        .ex_i       (ex_q),
        .if_stall_i (stall_q),
        .flush_i    (flush_q),
        .pred_o     (pred),
        .history_o  (hist)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    // instruction encoders, rv32 field layout
    function automatic xlen_t jal_inst(logic [4:0] rd, xlen_t off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t jalr_inst(logic [4:0] rd, logic [4:0] rs1, xlen_t off);
        return {off[11:0], rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic xlen_t branch_inst(xlen_t off);
        return {off[12], off[10:5], 5'd6, 5'd5, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic pred_t pred_of(logic is_branch, logic taken, xlen_t target);
        pred_t p;
        p.is_branch = is_branch;
        p.taken     = taken;
        p.target    = target;
        return p;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pred(string name, pred_t exp);
        if (pred !== exp) begin
            abort_run($sformatf("Fail %s expected %0b/%0b/%h actual %0b/%0b/%h", name,
                                exp.is_branch, exp.taken, exp.target,
                                pred.is_branch, pred.taken, pred.target));
        end
    endtask

    task automatic check_hist(string name, ghist_t exp);
        if (hist !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, hist));
        end
    endtask

    // one clock of stimulus, outputs are checked at the falling edge
    task automatic apply_cycle(if_req_t f, ex_res_t e, logic stall, logic fl);
        @(posedge clk);
        if_q    <= f;
        ex_q    <= e;
        stall_q <= stall;
        flush_q <= fl;
        @(negedge clk);
    endtask

    task automatic predict(xlen_t pc, xlen_t inst);
        if_req_t f;
        f.pc   = pc;
        f.inst = inst;
        apply_cycle(f, '0, 1'b0, 1'b0);
    endtask

    // result takes effect one cycle after it is presented
    task automatic resolve(xlen_t pc, xlen_t inst, logic taken, logic pdt_true, xlen_t target);
        ex_res_t e;
        e.valid    = 1'b1;
        e.taken    = taken;
        e.pdt_true = pdt_true;
        e.pc       = pc;
        e.history  = '0;
        e.target   = target;
        e.inst     = inst;
        apply_cycle(if_q, e, 1'b0, 1'b0);
        exp_hist = {exp_hist[14:0], taken};
        apply_cycle(if_q, '0, 1'b0, 1'b0);
    endtask

    task automatic test_jal();
        xlen_t pc;
        pc = 32'h0000_1000;
        predict(pc, jal_inst(REG_RA, 32'h0000_0800));
        check_pred("test_jal forward", pred_of(1'b1, 1'b1, pc + 32'h0000_0800));
        predict(pc + 32'h40, jal_inst(5'd0, 32'hffff_f7fc));
        check_pred("test_jal backward", pred_of(1'b1, 1'b1, pc + 32'h40 + 32'hffff_f7fc));
        predict(pc, NOP);
        check_pred("test_jal non-branch", pred_of(1'b0, 1'b0, pc + INST_STEP));
    endtask

    task automatic test_bimodal();
        xlen_t pc_a;
        xlen_t pc_b;
        xlen_t off;
        pc_a = 32'h0000_2010;
        pc_b = 32'h0000_2140;
        off  = 32'h0000_0100;
        predict(pc_a, branch_inst(off));
        check_pred("test_bimodal fresh", pred_of(1'b1, 1'b0, pc_a + INST_STEP));
        resolve(pc_a, branch_inst(off), 1'b1, 1'b0, 32'h0000_3000);
        predict(pc_a, branch_inst(off));
        check_pred("test_bimodal trained", pred_of(1'b1, 1'b1, 32'h0000_3000));
        // train pc_b, then evict its btb slot with a different tag
        resolve(pc_b, branch_inst(off), 1'b1, 1'b0, 32'h0000_7000);
        resolve(pc_b + 32'h0004_0000, jalr_inst(5'd0, 5'd5, '0), 1'b1, 1'b1, 32'h0000_7700);
        predict(pc_b, branch_inst(off));
        check_pred("test_bimodal btb miss", pred_of(1'b1, 1'b1, pc_b + off));
    endtask

    task automatic test_btb_jalr();
        xlen_t pc;
        pc = 32'h0000_4200;
        predict(pc, jalr_inst(5'd0, 5'd5, 32'h10));
        check_pred("test_btb_jalr miss", pred_of(1'b1, 1'b0, pc + INST_STEP));
        resolve(pc, jalr_inst(5'd0, 5'd5, 32'h10), 1'b1, 1'b0, 32'h0000_5a5c);
        predict(pc, jalr_inst(5'd0, 5'd5, 32'h10));
        check_pred("test_btb_jalr hit", pred_of(1'b1, 1'b1, 32'h0000_5a5c));
    endtask

    task automatic test_ras();
        xlen_t pc_a;
        xlen_t pc_b;
        xlen_t pc_r;
        xlen_t pc_r2;
        xlen_t ret;
        pc_a  = 32'h0000_6000;
        pc_b  = 32'h0000_6324;
        pc_r  = 32'h0000_6088;
        pc_r2 = 32'h0000_63f0;
        ret   = jalr_inst(5'd0, REG_RA, '0);
        resolve(pc_a, jal_inst(REG_RA, 32'h400), 1'b1, 1'b1, pc_a + 32'h400);
        resolve(pc_b, jal_inst(REG_RA, 32'h200), 1'b1, 1'b1, pc_b + 32'h200);
        predict(pc_r, ret);
        check_pred("test_ras inner", pred_of(1'b1, 1'b1, pc_b + INST_STEP));
        resolve(pc_r, ret, 1'b1, 1'b1, pc_b + INST_STEP);
        predict(pc_r, ret);
        check_pred("test_ras outer", pred_of(1'b1, 1'b1, pc_a + INST_STEP));
        resolve(pc_r, ret, 1'b1, 1'b1, pc_a + INST_STEP);
        predict(pc_r2, ret);
        check_pred("test_ras empty miss", pred_of(1'b1, 1'b0, pc_r2 + INST_STEP));
        predict(pc_r, ret);
        check_pred("test_ras empty hit", pred_of(1'b1, 1'b1, pc_a + INST_STEP));
    endtask

    task automatic test_history_flush();
        logic [5:0] bits;
        ex_res_t    e;
        if_req_t    f;
        bits = 6'b101101;
        check_hist("test_history_flush start", exp_hist);
        for (int i = 5; i >= 0; i--) begin
            resolve(32'h0000_8000, NOP, bits[i], 1'b1, 32'h0000_8004);
            check_hist("test_history_flush shift", exp_hist);
        end
        e.valid    = 1'b1;
        e.taken    = 1'b1;
        e.pdt_true = 1'b0;
        e.pc       = 32'h0000_8000;
        e.history  = 16'ha5c3;
        e.target   = 32'h0000_8004;
        e.inst     = NOP;
        f.pc       = 32'h0000_9000;
        f.inst     = jal_inst(REG_RA, 32'h80);
        apply_cycle(f, e, 1'b0, 1'b1);
        check_pred("test_history_flush during flush", pred_of(1'b0, 1'b0, 32'h0000_9004));
        apply_cycle(f, '0, 1'b0, 1'b0);
        exp_hist = 16'ha5c3;
        check_hist("test_history_flush restore", exp_hist);
        // a stalled result is dropped
        apply_cycle(f, e, 1'b1, 1'b0);
        check_pred("test_history_flush during stall", pred_of(1'b0, 1'b0, 32'h0000_9004));
        apply_cycle(f, '0, 1'b0, 1'b0);
        check_hist("test_history_flush after stall", exp_hist);
        check_pred("test_history_flush resume", pred_of(1'b1, 1'b1, 32'h0000_9080));
    endtask

    initial begin
        rst      <= 1'b1;
        if_q     <= '0;
        ex_q     <= '0;
        stall_q  <= 1'b0;
        flush_q  <= 1'b0;
        exp_hist = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_pred("reset", pred_of(1'b0, 1'b0, INST_STEP));
        check_hist("reset", exp_hist);
        test_jal();
        test_bimodal();
        test_btb_jalr();
        test_ras();
        test_history_flush();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
common/bpu_pkg.sv
rtl/bpu_ctrl.sv
btb/bpu_btb.sv
pht/bpu_pht.sv
ras/bpu_ras.sv
rtl/bpu_top.sv
bench/bpu_assert.sv
bench/tb_bpu.sv

// ==== Makefile ====
TOP := tb_bpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
